// File: design/bfm_pkg.sv
package bfm_pkg;

	// --------------------------------------------------
	// AXI4-Lite register port
	// --------------------------------------------------
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
	// Word aligned, register index sits above the byte offset
	localparam int ADDR_LSB = 2;

	// Register map by index
	localparam logic [AXIL_ADDR_W-ADDR_LSB-1:0] REG_WPTR = 2'd0;
	localparam logic [AXIL_ADDR_W-ADDR_LSB-1:0] REG_RPTR = 2'd1;
	localparam logic [AXIL_ADDR_W-ADDR_LSB-1:0] REG_SCRATCH0 = 2'd2;
	localparam logic [AXIL_ADDR_W-ADDR_LSB-1:0] REG_SCRATCH1 = 2'd3;

	// Only OKAY is ever returned
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// --------------------------------------------------
	// Stream side and result buffer
	// --------------------------------------------------
	localparam int STREAM_W = 32;
	localparam int BUFFER_BYTES = 64;
	// One extra bit so a pointer can hold the full count
	localparam int PTR_W = 7;
	localparam int PAIR_BYTES = 2;
	localparam int WORD_BYTES = 4;

	// Stream word, seen whole or as four bytes with a lowest
	typedef union packed {
		logic [STREAM_W-1:0] word;
		struct packed {
			logic [7:0] d;
			logic [7:0] c;
			logic [7:0] b;
			logic [7:0] a;
		} bytes;
	} stream_word_t;

endpackage

// File: design/axil_regs.sv
`timescale 1ns/10ps

module axil_regs (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic [bfm_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
	input  logic s_axi_awvalid,
	output logic s_axi_awready,
	input  logic [bfm_pkg::AXIL_DATA_W-1:0] s_axi_wdata,
	input  logic [bfm_pkg::AXIL_STRB_W-1:0] s_axi_wstrb,
	input  logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input  logic s_axi_bready,
	input  logic [bfm_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
	input  logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [bfm_pkg::AXIL_DATA_W-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input  logic s_axi_rready,
	input  logic [bfm_pkg::PTR_W-1:0] wr_ptr,
	input  logic [bfm_pkg::PTR_W-1:0] rd_ptr
);

	// Write slot free, only one write in flight
	logic aw_en;
	// Address and data both present, slot free
	logic wr_take;
	logic [bfm_pkg::AXIL_ADDR_W-bfm_pkg::ADDR_LSB-1:0] wr_idx;
	logic [bfm_pkg::AXIL_ADDR_W-bfm_pkg::ADDR_LSB-1:0] ar_idx;
	logic ar_take;
	logic [bfm_pkg::AXIL_DATA_W-1:0] scratch0;
	logic [bfm_pkg::AXIL_DATA_W-1:0] scratch1;
	logic [bfm_pkg::AXIL_DATA_W-1:0] rd_mux;

	// --------------------------------------------------
	// Write path
	// --------------------------------------------------
	assign wr_take = !s_axi_awready && s_axi_awvalid && s_axi_wvalid && aw_en;
	assign wr_idx = s_axi_awaddr[bfm_pkg::AXIL_ADDR_W-1:bfm_pkg::ADDR_LSB];
	assign s_axi_bresp = bfm_pkg::RESP_OKAY;

	// AWREADY and WREADY pulse together, slot closes until B is taken
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			aw_en <= 1'b1;
		end
		else
		begin
			s_axi_awready <= wr_take;
			s_axi_wready <= wr_take;
			if (wr_take)
				aw_en <= 1'b0;
			else if (s_axi_bvalid && s_axi_bready)
				aw_en <= 1'b1;
		end
	end

	// Scratch update on the same edge as the ready pulse
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			scratch0 <= '0;
			scratch1 <= '0;
		end
		else if (wr_take)
		begin
			for (int i = 0; i < bfm_pkg::AXIL_STRB_W; i++)
			begin
				if (s_axi_wstrb[i])
				begin
					case (wr_idx)
						bfm_pkg::REG_SCRATCH0: scratch0[8*i +: 8] <= s_axi_wdata[8*i +: 8];
						bfm_pkg::REG_SCRATCH1: scratch1[8*i +: 8] <= s_axi_wdata[8*i +: 8];
						// Pointer registers are read only, write is acked and dropped
						default: ;
					endcase
				end
			end
		end
	end

	// Response one edge after the ready pulse, held until BREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			s_axi_bvalid <= 1'b0;
		else if (s_axi_awready)
			s_axi_bvalid <= 1'b1;
		else if (s_axi_bready)
			s_axi_bvalid <= 1'b0;
	end

	// --------------------------------------------------
	// Read path
	// --------------------------------------------------
	// Hold off a new address while read data waits
	assign ar_take = !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
	assign s_axi_rresp = bfm_pkg::RESP_OKAY;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end
		else
		begin
			s_axi_arready <= ar_take;
			if (s_axi_arready)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	// Index latch and data sample
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_take)
			ar_idx <= s_axi_araddr[bfm_pkg::AXIL_ADDR_W-1:bfm_pkg::ADDR_LSB];
		// Pointers are sampled as RVALID rises
		if (s_axi_arready)
			s_axi_rdata <= rd_mux;
	end

	// Pointers zero extended
	always_comb
	begin
		case (ar_idx)
			bfm_pkg::REG_WPTR: rd_mux = {{(bfm_pkg::AXIL_DATA_W-bfm_pkg::PTR_W){1'b0}}, wr_ptr};
			bfm_pkg::REG_RPTR: rd_mux = {{(bfm_pkg::AXIL_DATA_W-bfm_pkg::PTR_W){1'b0}}, rd_ptr};
			bfm_pkg::REG_SCRATCH0: rd_mux = scratch0;
			bfm_pkg::REG_SCRATCH1: rd_mux = scratch1;
			default: rd_mux = '0;
		endcase
	end

endmodule

// File: design/stream_sink.sv
`timescale 1ns/10ps

module stream_sink (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic s_axis_tvalid,
	input  logic s_axis_tlast,
	output logic s_axis_tready,
	output logic beat_accept
);

	// FSM state, 0 idle and 1 write
	logic in_write;
	// TLAST taken on the previous beat
	logic last_seen;

	// Ready only in the write state
	assign s_axis_tready = in_write;
	assign beat_accept = s_axis_tvalid && s_axis_tready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			in_write <= 1'b0;
			last_seen <= 1'b0;
		end
		else
		begin
			last_seen <= beat_accept && s_axis_tlast;
			// Idle waits for the first TVALID
			if (!in_write)
				in_write <= s_axis_tvalid;
			// Packet closed, back to idle
			else if (last_seen)
				in_write <= 1'b0;
		end
	end

endmodule

// File: design/pair_adder.sv
`timescale 1ns/10ps

module pair_adder (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic beat_accept,
	input  bfm_pkg::stream_word_t s_axis_tdata,
	output logic pair_valid,
	output logic [bfm_pkg::PAIR_BYTES*8-1:0] pair_data
);

	// Stage 1, accepted word
	bfm_pkg::stream_word_t word_q;
	logic word_valid;
	// Stage 2, lane sums
	logic [bfm_pkg::PAIR_BYTES*8-1:0] sum_q;

	// Word capture on accept
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (beat_accept)
			word_q <= s_axis_tdata;
	end

	// Lane 0 in the low byte, lane 1 above
	// Sums wrap at 8 bits
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (word_valid)
		begin
			sum_q[7:0] <= word_q.bytes.a + word_q.bytes.b;
			sum_q[15:8] <= word_q.bytes.c + word_q.bytes.d;
		end
	end

	// Valid follows the data through both stages
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			word_valid <= 1'b0;
			pair_valid <= 1'b0;
		end
		else
		begin
			word_valid <= beat_accept;
			pair_valid <= word_valid;
		end
	end

	assign pair_data = sum_q;

endmodule

// File: design/result_buffer.sv
`timescale 1ns/10ps

module result_buffer (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic pair_valid,
	input  logic [bfm_pkg::PAIR_BYTES*8-1:0] pair_data,
	input  logic [bfm_pkg::PTR_W-1:0] rd_ptr,
	output bfm_pkg::stream_word_t rd_word,
	output logic [bfm_pkg::PTR_W-1:0] wr_ptr
);

	logic [7:0] mem [bfm_pkg::BUFFER_BYTES];
	// Byte addresses, pointer without its count bit
	logic [bfm_pkg::PTR_W-2:0] wr_addr;
	logic [bfm_pkg::PTR_W-2:0] rd_addr;
	// Room left, results past a full buffer are lost
	logic wr_en;

	assign wr_addr = wr_ptr[bfm_pkg::PTR_W-2:0];
	assign rd_addr = rd_ptr[bfm_pkg::PTR_W-2:0];
	assign wr_en = pair_valid && (wr_ptr < (bfm_pkg::PTR_W)'(bfm_pkg::BUFFER_BYTES));

	// Write pointer saturates at the buffer size
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_ptr <= '0;
		else if (wr_en)
			wr_ptr <= wr_ptr + (bfm_pkg::PTR_W)'(bfm_pkg::PAIR_BYTES);
	end

	// Low lane to the lower address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_en)
		begin
			for (int i = 0; i < bfm_pkg::PAIR_BYTES; i++)
				mem[wr_addr + (bfm_pkg::PTR_W-1)'(i)] <= pair_data[8*i +: 8];
		end
	end

	// Four bytes at rd_ptr, little endian
	always_comb
	begin
		for (int i = 0; i < bfm_pkg::WORD_BYTES; i++)
			rd_word.word[8*i +: 8] = mem[rd_addr + (bfm_pkg::PTR_W-1)'(i)];
	end

endmodule

// File: design/stream_source.sv
`timescale 1ns/10ps

module stream_source (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic [bfm_pkg::PTR_W-1:0] wr_ptr,
	input  bfm_pkg::stream_word_t rd_word,
	input  logic m_axis_tready,
	output logic m_axis_tvalid,
	output bfm_pkg::stream_word_t m_axis_tdata,
	output logic m_axis_tlast,
	output logic [bfm_pkg::PTR_W-1:0] rd_ptr
);

	// Load strobe, also steps rd_ptr
	logic rd_advance;
	// Output register empty or draining this cycle
	logic slot_free;
	// Four bytes at rd_ptr already written
	logic bytes_ready;
	// Word at rd_ptr is the final one of the buffer
	logic final_word;
	// Set once the final word is loaded, rd_ptr at the end
	logic done;

	assign slot_free = !m_axis_tvalid || m_axis_tready;
	assign bytes_ready = (rd_ptr + (bfm_pkg::PTR_W)'(bfm_pkg::WORD_BYTES)) <= wr_ptr;
	assign final_word = rd_ptr ==
		(bfm_pkg::PTR_W)'(bfm_pkg::BUFFER_BYTES - bfm_pkg::WORD_BYTES);
	assign rd_advance = !done && slot_free && bytes_ready;

	// --------------------------------------------------
	// Control, valid and last with the pointer
	// --------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast <= 1'b0;
			rd_ptr <= '0;
			done <= 1'b0;
		end
		else if (rd_advance)
		begin
			m_axis_tvalid <= 1'b1;
			m_axis_tlast <= final_word;
			rd_ptr <= rd_ptr + (bfm_pkg::PTR_W)'(bfm_pkg::WORD_BYTES);
			// No more loads until reset
			done <= final_word;
		end
		else if (m_axis_tready)
		begin
			// Word taken and nothing new to show
			m_axis_tvalid <= 1'b0;
			m_axis_tlast <= 1'b0;
		end
	end

	// Output word, held under back-pressure
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_advance)
			m_axis_tdata <= rd_word;
	end

endmodule

// File: design/bfm.sv
`timescale 1ns/10ps

module bfm (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// AXI4-Lite slave
	input  logic [bfm_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
	input  logic s_axi_awvalid,
	output logic s_axi_awready,
	input  logic [bfm_pkg::AXIL_DATA_W-1:0] s_axi_wdata,
	input  logic [bfm_pkg::AXIL_STRB_W-1:0] s_axi_wstrb,
	input  logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input  logic s_axi_bready,
	input  logic [bfm_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
	input  logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [bfm_pkg::AXIL_DATA_W-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input  logic s_axi_rready,
	// AXI4-Stream in
	input  logic s_axis_tvalid,
	output logic s_axis_tready,
	input  bfm_pkg::stream_word_t s_axis_tdata,
	input  logic s_axis_tlast,
	// AXI4-Stream out
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output bfm_pkg::stream_word_t m_axis_tdata,
	output logic m_axis_tlast
);

	logic beat_accept;
	logic pair_valid;
	logic [bfm_pkg::PAIR_BYTES*8-1:0] pair_data;
	logic [bfm_pkg::PTR_W-1:0] wr_ptr;
	logic [bfm_pkg::PTR_W-1:0] rd_ptr;
	bfm_pkg::stream_word_t rd_word;

	// --------------------------------------------------
	// Register slave, pointer readback
	// --------------------------------------------------
	axil_regs i_axil_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.wr_ptr        (wr_ptr),
		.rd_ptr        (rd_ptr)
	);

	// --------------------------------------------------
	// Stream in, lane sums, buffer, stream out
	// --------------------------------------------------
	stream_sink i_stream_sink (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.beat_accept   (beat_accept)
	);

	pair_adder i_pair_adder (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.beat_accept   (beat_accept),
		.s_axis_tdata  (s_axis_tdata),
		.pair_valid    (pair_valid),
		.pair_data     (pair_data)
	);

	result_buffer i_result_buffer (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.pair_valid    (pair_valid),
		.pair_data     (pair_data),
		.rd_ptr        (rd_ptr),
		.rd_word       (rd_word),
		.wr_ptr        (wr_ptr)
	);

	// Reads only what the buffer already holds
	stream_source i_stream_source (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_ptr        (wr_ptr),
		.rd_word       (rd_word),
		.m_axis_tready (m_axis_tready),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast),
		.rd_ptr        (rd_ptr)
	);

endmodule

// File: testbench/bfm_chk.sv
`timescale 1ns/10ps

module bfm_chk (
	input logic clk,
	input logic rstn,
	input logic valid,
	input logic ready,
	input logic [bfm_pkg::STREAM_W-1:0] data,
	input logic last,
	input logic bvalid,
	input logic bready
);

	// --------------------------------------------------
	// Stream source output register
	// --------------------------------------------------
	// Stalled word keeps valid, data and last
	assert property (@(posedge clk) disable iff (!rstn)
		valid && !ready |=> valid && $stable(data) && $stable(last))
		else $error("stream word changed while stalled");

	// Last only ever rides on a valid word
	assert property (@(posedge clk) disable iff (!rstn) last |-> valid)
		else $error("stream last without valid");

	// --------------------------------------------------
	// Write response channel
	// --------------------------------------------------
	assert property (@(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

endmodule

// Stream side, response channel tied off
bind stream_source bfm_chk i_bfm_chk (
	.clk    (S_AXI_ACLK),
	.rstn   (S_AXI_ARESETN),
	.valid  (m_axis_tvalid),
	.ready  (m_axis_tready),
	.data   (m_axis_tdata),
	.last   (m_axis_tlast),
	.bvalid (1'b0),
	.bready (1'b1)
);

// Register side, stream tied off
bind axil_regs bfm_chk i_bfm_chk (
	.clk    (S_AXI_ACLK),
	.rstn   (S_AXI_ARESETN),
	.valid  (1'b0),
	.ready  (1'b1),
	.data   ('0),
	.last   (1'b0),
	.bvalid (s_axi_bvalid),
	.bready (s_axi_bready)
);

// File: testbench/tb_bfm.sv
`timescale 1ns/10ps

module tb_bfm;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [bfm_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [bfm_pkg::AXIL_DATA_W-1:0] s_axi_wdata;
	logic [bfm_pkg::AXIL_STRB_W-1:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [bfm_pkg::AXIL_ADDR_W-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [bfm_pkg::AXIL_DATA_W-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic s_axis_tvalid;
	logic s_axis_tready;
	bfm_pkg::stream_word_t s_axis_tdata;
	logic s_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready;
	bfm_pkg::stream_word_t m_axis_tdata;
	logic m_axis_tlast;

	// Pattern commands, fields x, y, z per op
	string op_q[$];
	int x_q[$];
	logic [31:0] y_q[$];
	logic [31:0] z_q[$];
	// Words sent and words seen on the output
	bfm_pkg::stream_word_t in_words[$];
	bfm_pkg::stream_word_t out_words[$];
	logic out_last[$];
	int tests;
	int errors;
	int cycles;
	int cycle_limit;

	bfm i_bfm (.*);

	initial S_AXI_ACLK = 1'b0;
	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	// --------------------------------------------------
	// Run limit, random back-pressure, output monitor
	// --------------------------------------------------
	always @(posedge S_AXI_ACLK)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Checks failed");
			$finish;
		end
	end

	always @(posedge S_AXI_ACLK)
	begin
		#2;
		m_axis_tready = ($urandom % 4) != 0;
	end

	// Mid-cycle sample, handshake completes on the next rising edge
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && m_axis_tvalid && m_axis_tready)
		begin
			out_words.push_back(m_axis_tdata);
			out_last.push_back(m_axis_tlast);
		end
	end

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
		tests++;
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s expected %08h actual %08h", name, exp, act);
		end
		else
			$display("%s ok", name);
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		tests++;
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s expected resp %0d actual resp %0d", name, exp, act);
		end
		else
			$display("%s ok", name);
	endtask

	task automatic check_stream(input string name, input bfm_pkg::stream_word_t exp,
		input logic exp_last, input bfm_pkg::stream_word_t act, input logic act_last);
		tests++;
		if (exp !== act || exp_last !== act_last)
		begin
			errors++;
			$display("[ERROR] %s expected %08h last %0b actual %08h last %0b",
				name, exp.word, exp_last, act.word, act_last);
		end
		else
			$display("%s ok", name);
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		tests++;
		if (exp != act)
		begin
			errors++;
			$display("[ERROR] %s expected %0d words actual %0d words", name, exp, act);
		end
		else
			$display("%s ok", name);
	endtask

	// Output k carries the lane sums of inputs 2k and 2k+1, low lane first
	function automatic bfm_pkg::stream_word_t expected_word(input int k);
		bfm_pkg::stream_word_t w0;
		bfm_pkg::stream_word_t w1;
		bfm_pkg::stream_word_t r;
		w0 = in_words[2*k];
		w1 = in_words[2*k+1];
		r.bytes.a = w0.bytes.a + w0.bytes.b;
		r.bytes.b = w0.bytes.c + w0.bytes.d;
		r.bytes.c = w1.bytes.a + w1.bytes.b;
		r.bytes.d = w1.bytes.c + w1.bytes.d;
		return r;
	endfunction

	// --------------------------------------------------
	// AXI4-Lite and stream drivers
	// --------------------------------------------------
	task automatic reg_write(input int idx, input logic [3:0] strb, input logic [31:0] data,
		output logic [1:0] resp);
		s_axi_awaddr = {2'(idx), 2'b00};
		s_axi_wdata = data;
		s_axi_wstrb = strb;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		s_axi_bready = 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_awready);
		@(posedge S_AXI_ACLK);
		#2;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		do @(negedge S_AXI_ACLK); while (!s_axi_bvalid);
		resp = s_axi_bresp;
		@(posedge S_AXI_ACLK);
		#2;
		s_axi_bready = 1'b0;
	endtask

	task automatic reg_read(input int idx, output logic [31:0] data, output logic [1:0] resp);
		s_axi_araddr = {2'(idx), 2'b00};
		s_axi_arvalid = 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_arready);
		@(posedge S_AXI_ACLK);
		#2;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_rvalid);
		data = s_axi_rdata;
		resp = s_axi_rresp;
		@(posedge S_AXI_ACLK);
		#2;
		s_axi_rready = 1'b0;
	endtask

	// Burst of count words, start plus step per word, TLAST on the final one
	task automatic send_burst(input int count, input logic [31:0] start, input logic [31:0] step);
		for (int i = 0; i < count; i++)
		begin
			s_axis_tdata.word = start + step * 32'(i);
			s_axis_tlast = (i == count - 1);
			s_axis_tvalid = 1'b1;
			in_words.push_back(s_axis_tdata);
			do @(negedge S_AXI_ACLK); while (!s_axis_tready);
			@(posedge S_AXI_ACLK);
			#2;
		end
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic read_patterns();
		int fd;
		int code;
		string op;
		string rest;
		int x;
		logic [31:0] y;
		logic [31:0] z;
		fd = $fopen("testbench/bfm_patterns.txt", "r");
		if (fd == 0)
		begin
			tests++;
			errors++;
			$display("Pattern file testbench/bfm_patterns.txt could not be opened");
		end
		else
		begin
			while (!$feof(fd))
			begin
				x = 0;
				y = '0;
				z = '0;
				code = $fscanf(fd, " %s", op);
				if (code != 1)
					break;
				case (op)
					"#": code = $fgets(rest, fd);
					"W", "S", "P", "O": code = $fscanf(fd, "%d %h %h", x, y, z);
					"R": code = $fscanf(fd, "%d %h", x, z);
					default: code = $fscanf(fd, "%d", x);
				endcase
				if (op != "#")
				begin
					op_q.push_back(op);
					x_q.push_back(x);
					y_q.push_back(y);
					z_q.push_back(z);
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		logic [31:0] data;
		logic [1:0] resp;
		int reg_ops;
		int words;
		int tries;
		string name;
		void'($urandom(37203));
		S_AXI_ARESETN = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata = '0;
		s_axis_tlast = 1'b0;
		m_axis_tready = 1'b0;
		tests = 0;
		errors = 0;
		cycles = 0;
		cycle_limit = 0;
		reg_ops = 0;
		words = 0;
		read_patterns();
		foreach (op_q[i])
		begin
			if (op_q[i] == "W" || op_q[i] == "R")
				reg_ops++;
			else if (op_q[i] == "P")
				reg_ops += int'(y_q[i]);
			else if (op_q[i] == "S")
				words += x_q[i];
		end
		cycle_limit = reg_ops * 10 + words * 12 + 200;
		repeat (16) @(posedge S_AXI_ACLK);
		#2;
		S_AXI_ARESETN = 1'b1;
		foreach (op_q[i])
		begin
			name = $sformatf("step %0d %s", i, op_q[i]);
			case (op_q[i])
				"W":
				begin
					reg_write(x_q[i], y_q[i][3:0], z_q[i], resp);
					check_resp(name, bfm_pkg::RESP_OKAY, resp);
				end
				"R":
				begin
					reg_read(x_q[i], data, resp);
					check_resp({name, " resp"}, bfm_pkg::RESP_OKAY, resp);
					check_reg(name, z_q[i], data);
				end
				"P":
				begin
					tries = 0;
					do
					begin
						reg_read(x_q[i], data, resp);
						tries++;
					end
					while (data !== z_q[i] && tries < int'(y_q[i]));
					check_reg(name, z_q[i], data);
				end
				"S": send_burst(x_q[i], y_q[i], z_q[i]);
				"I":
				begin
					repeat (x_q[i]) @(posedge S_AXI_ACLK);
					#2;
				end
				"E": check_count(name, x_q[i], out_words.size());
				"D":
				begin
					while (out_words.size() < x_q[i])
					begin
						@(posedge S_AXI_ACLK);
						#2;
					end
					for (int k = 0; k < x_q[i]; k++)
						check_stream($sformatf("%s word %0d", name, k), expected_word(k),
							k == bfm_pkg::BUFFER_BYTES / bfm_pkg::WORD_BYTES - 1,
							out_words[k], out_last[k]);
				end
				"O":
				begin
					if (x_q[i] < out_words.size())
						check_stream(name, z_q[i], y_q[i][0], out_words[x_q[i]], out_last[x_q[i]]);
					else
					begin
						tests++;
						errors++;
						$display("%s: output word %0d never arrived", name, x_q[i]);
					end
				end
				default:
				begin
					tests++;
					errors++;
					$display("%s: unknown pattern command", name);
				end
			endcase
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: testbench/bfm_patterns.txt
# W idx strb data | R idx expected | P idx tries expected | S count start step
# E outputs so far | I idle cycles | D outputs to drain | O index last expected
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
E 0
W 2 f 11223344
W 2 4 00aa0000
R 2 11aa3344
W 3 3 0000beef
W 3 8 5a000000
R 3 5a00beef
W 0 f ffffffff
W 1 f 12345678
R 0 00000000
R 1 00000000
S 8 c1c2c3c4 01010101
P 0 30 00000010
S 24 c9cacbcc 01010101
D 16
O 0 0 85898387
O 15 1 c1c5bfc3
R 0 00000040
R 1 00000040
S 4 01020304 00000001
I 40
E 16

// File: compile.f
design/bfm_pkg.sv
design/axil_regs.sv
design/stream_sink.sv
design/pair_adder.sv
design/result_buffer.sv
design/stream_source.sv
design/bfm.sv
testbench/bfm_chk.sv
testbench/tb_bfm.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bfm -Mdir obj_dir -o sim_bfm -f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_bfm > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	exit 1
fi
exit 0
